// ==== lm80c_mem.f ====
src/lm80c_map_pkg.sv
src/lm80c_timing_pkg.sv
src/lm80c_clock_enables.sv
src/lm80c_write_decode.sv
src/lm80c_bram.sv
src/lm80c_read_return.sv
src/lm80c_mem_top.sv
bench/lm80c_clock_gen.sv
bench/lm80c_mem_properties.sv
bench/lm80c_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LM80C memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module lm80c_mem_tb -f lm80c_mem.f -o lm80c_mem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/lm80c_mem_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== bench/lm80c_mem_tb.sv ====
`timescale 1ns/1ps

module lm80c_mem_tb;

	// Step kinds
	localparam logic [2:0] K_DL = 3'd0;
	localparam logic [2:0] K_ER = 3'd1;
	localparam logic [2:0] K_CPU_WR = 3'd2;
	localparam logic [2:0] K_RD = 3'd3;
	localparam logic [2:0] K_ALL_WR = 3'd4;
	localparam logic [2:0] K_ER_CPU_WR = 3'd5;
	localparam logic [2:0] K_CTRL = 3'd6;

	logic clk_cpu;
	logic rst;
	logic dl_active;
	logic dl_wr;
	lm80c_map_pkg::load_addr_u dl_addr;
	lm80c_map_pkg::data_t dl_data;
	logic erase_busy;
	logic erase_wr;
	lm80c_map_pkg::load_addr_u erase_addr;
	lm80c_map_pkg::data_t erase_data;
	logic rom_loaded;
	logic reset_key;
	logic menu_reset;
	lm80c_map_pkg::cpu_addr_t cpu_addr;
	lm80c_map_pkg::data_t cpu_wdata;
	logic cpu_wr;
	logic cpu_rd;
	logic rom_enabled;
	lm80c_map_pkg::data_t cpu_rdata;
	logic cpu_rdata_valid;
	logic cpu_reset;
	logic cpu_wait;
	logic cpu_ena;
	logic psg_ena;
	logic vdp_ena;

	// Step table, one entry per clock
	logic [2:0] step_kind [$];
	logic [lm80c_map_pkg::LOAD_ADDR_W-1:0] step_addr [$];
	logic step_rom_en [$];
	// rom_loaded, reset_key, erase_busy, menu_reset, dl_active
	logic [4:0] step_ctrl [$];
	logic step_exp_reset [$];
	logic step_exp_wait [$];
	string step_name [$];

	// Expected array contents
	lm80c_map_pkg::data_t rom_model [0:(1 << lm80c_map_pkg::ROM_ADDR_W)-1];
	lm80c_map_pkg::data_t ram_model [0:(1 << lm80c_map_pkg::RAM_ADDR_W)-1];

	// Reads in flight
	lm80c_map_pkg::data_t exp_q [$];
	string exp_name_q [$];

	// Last byte returned, cpu_rdata keeps it until the next read
	lm80c_map_pkg::data_t held_rdata;
	logic held_known = 1'b0;

	integer seed = 50826;
	int cycle_cnt = 0;
	int timeout_limit = 0;
	logic rd_d1 = 1'b0;
	logic rd_d2 = 1'b0;
	logic [lm80c_timing_pkg::ENA_DIV_W:0] cpu_ena_cnt;
	logic [lm80c_timing_pkg::ENA_DIV_W:0] psg_ena_cnt;
	logic [lm80c_timing_pkg::ENA_DIV_W:0] vdp_ena_cnt;

	lm80c_clock_gen #(
		.PERIOD_NS(20)
	) clock_gen_i (
		.clk_cpu(clk_cpu)
	);

	lm80c_mem_top lm80c_mem_top_i (
		.clk_cpu(clk_cpu),
		.rst(rst),
		.dl_active(dl_active),
		.dl_wr(dl_wr),
		.dl_addr(dl_addr),
		.dl_data(dl_data),
		.erase_busy(erase_busy),
		.erase_wr(erase_wr),
		.erase_addr(erase_addr),
		.erase_data(erase_data),
		.rom_loaded(rom_loaded),
		.reset_key(reset_key),
		.menu_reset(menu_reset),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_wr(cpu_wr),
		.cpu_rd(cpu_rd),
		.rom_enabled(rom_enabled),
		.cpu_rdata(cpu_rdata),
		.cpu_rdata_valid(cpu_rdata_valid),
		.cpu_reset(cpu_reset),
		.cpu_wait(cpu_wait),
		.cpu_ena(cpu_ena),
		.psg_ena(psg_ena),
		.vdp_ena(vdp_ena)
	);

	// Decoder assertions, clocked from the testbench clock
	bind lm80c_write_decode lm80c_mem_properties write_decode_props_i (
		.clk_cpu(lm80c_mem_tb.clk_cpu),
		.rst(rst),
		.dl_active(dl_active),
		.dl_wr(dl_wr),
		.dl_addr(dl_addr),
		.erase_busy(erase_busy),
		.erase_wr(erase_wr),
		.cpu_wr(cpu_wr),
		.cpu_rom_sel(cpu_rom_sel),
		.rom_we(rom_we),
		.ram_we(ram_we)
	);

	// ------------------------------------------------------------------------
	// Error handling and compare tasks
	// ------------------------------------------------------------------------
	task automatic abort_run();
		$display("Verification failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_data(input string name, input lm80c_map_pkg::data_t exp,
			input lm80c_map_pkg::data_t act);
		if (act !== exp) begin
			$display("ERR %s: expected %02h, actual %02h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s: expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(input string name,
			input logic [lm80c_timing_pkg::ENA_DIV_W:0] exp,
			input logic [lm80c_timing_pkg::ENA_DIV_W:0] act);
		if (act !== exp) begin
			$display("ERR %s: expected %0d, actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	// ------------------------------------------------------------------------
	// Memory map model
	// ------------------------------------------------------------------------

	// Loader map, ROM image low, RAM image in 0x10000-0x1FFFF, rest dropped
	function automatic void store_loader(input logic [lm80c_map_pkg::LOAD_ADDR_W-1:0] addr,
			input lm80c_map_pkg::data_t data);
		if (addr < 25'h0008000) begin
			rom_model[addr[lm80c_map_pkg::ROM_ADDR_W-1:0]] = data;
		end else if ((addr >= 25'h0010000) && (addr < 25'h0020000)) begin
			ram_model[addr[lm80c_map_pkg::RAM_ADDR_W-1:0]] = data;
		end
	endfunction

	// CPU writes land in RAM unless the ROM overlay covers them
	function automatic void store_cpu(input lm80c_map_pkg::cpu_addr_t addr, input logic rom_en,
			input lm80c_map_pkg::data_t data);
		if (!(rom_en && (addr < 16'h8000))) begin
			ram_model[addr] = data;
		end
	endfunction

	function automatic lm80c_map_pkg::data_t expect_read(input lm80c_map_pkg::cpu_addr_t addr,
			input logic rom_en);
		if (rom_en && (addr < 16'h8000)) begin
			return rom_model[addr[lm80c_map_pkg::ROM_ADDR_W-1:0]];
		end
		return ram_model[addr];
	endfunction

	// ------------------------------------------------------------------------
	// Step table
	// ------------------------------------------------------------------------
	function automatic void add_step(input logic [2:0] kind,
			input logic [lm80c_map_pkg::LOAD_ADDR_W-1:0] addr, input logic rom_en,
			input logic [4:0] ctrl, input logic exp_reset, input logic exp_wait,
			input string name);
		step_kind.push_back(kind);
		step_addr.push_back(addr);
		step_rom_en.push_back(rom_en);
		step_ctrl.push_back(ctrl);
		step_exp_reset.push_back(exp_reset);
		step_exp_wait.push_back(exp_wait);
		step_name.push_back(name);
	endfunction

	function automatic void load_table();
		// ROM image, then back-to-back reads
		add_step(K_DL, 25'h0000010, 1'b1, 5'b10000, 1'b0, 1'b0, "dl rom 0x0010");
		add_step(K_DL, 25'h0007FFF, 1'b1, 5'b10000, 1'b0, 1'b0, "dl rom 0x7fff");
		add_step(K_DL, 25'h0000011, 1'b1, 5'b10000, 1'b0, 1'b0, "dl rom 0x0011");
		add_step(K_RD, 25'h0000010, 1'b1, 5'b10000, 1'b0, 1'b0, "rd rom 0x0010");
		add_step(K_RD, 25'h0007FFF, 1'b1, 5'b10000, 1'b0, 1'b0, "rd rom 0x7fff");
		add_step(K_RD, 25'h0000011, 1'b1, 5'b10000, 1'b0, 1'b0, "rd rom 0x0011");
		// RAM image and the holes
		add_step(K_DL, 25'h0010010, 1'b0, 5'b10000, 1'b0, 1'b0, "dl ram 0x0010");
		add_step(K_DL, 25'h001ABCD, 1'b0, 5'b10000, 1'b0, 1'b0, "dl ram 0xabcd");
		add_step(K_DL, 25'h0008010, 1'b0, 5'b10000, 1'b0, 1'b0, "dl hole 0x08010");
		add_step(K_DL, 25'h0020010, 1'b0, 5'b10000, 1'b0, 1'b0, "dl hole 0x20010");
		add_step(K_DL, 25'h0FF0010, 1'b0, 5'b10000, 1'b0, 1'b0, "dl hole 0xff0010");
		add_step(K_RD, 25'h0000010, 1'b0, 5'b10000, 1'b0, 1'b0, "rd ram 0x0010");
		add_step(K_RD, 25'h000ABCD, 1'b0, 5'b10000, 1'b0, 1'b0, "rd ram 0xabcd");
		add_step(K_RD, 25'h0000010, 1'b1, 5'b10000, 1'b0, 1'b0, "rd rom 0x0010 again");
		// CPU writes under and outside the overlay
		add_step(K_DL, 25'h0010011, 1'b0, 5'b10000, 1'b0, 1'b0, "dl ram 0x0011");
		add_step(K_CPU_WR, 25'h0000011, 1'b1, 5'b10000, 1'b0, 1'b0, "cpu wr overlay");
		add_step(K_RD, 25'h0000011, 1'b1, 5'b10000, 1'b0, 1'b0, "rd rom after cpu wr");
		add_step(K_RD, 25'h0000011, 1'b0, 5'b10000, 1'b0, 1'b0, "rd ram after cpu wr");
		add_step(K_CPU_WR, 25'h0000011, 1'b0, 5'b10000, 1'b0, 1'b0, "cpu wr ram 0x0011");
		add_step(K_RD, 25'h0000011, 1'b0, 5'b10000, 1'b0, 1'b0, "rd ram 0x0011 new");
		add_step(K_RD, 25'h0000011, 1'b1, 5'b10000, 1'b0, 1'b0, "rd rom 0x0011 kept");
		add_step(K_CPU_WR, 25'h0009000, 1'b1, 5'b10000, 1'b0, 1'b0, "cpu wr ram 0x9000");
		add_step(K_RD, 25'h0009000, 1'b1, 5'b10000, 1'b0, 1'b0, "rd ram 0x9000");
		// Priority between sources
		add_step(K_ALL_WR, 25'h0010200, 1'b0, 5'b10000, 1'b0, 1'b0, "dl over erase and cpu");
		add_step(K_RD, 25'h0000200, 1'b0, 5'b10000, 1'b0, 1'b0, "rd ram 0x0200");
		add_step(K_ER_CPU_WR, 25'h0010300, 1'b0, 5'b10000, 1'b0, 1'b0, "erase over cpu");
		add_step(K_RD, 25'h0000300, 1'b0, 5'b10000, 1'b0, 1'b0, "rd ram 0x0300");
		add_step(K_ER, 25'h0000020, 1'b1, 5'b10000, 1'b0, 1'b0, "erase rom 0x0020");
		add_step(K_RD, 25'h0000020, 1'b1, 5'b10000, 1'b0, 1'b0, "rd rom 0x0020");
		// Erase into ROM while the CPU aims at the same RAM byte
		add_step(K_ER_CPU_WR, 25'h0000011, 1'b0, 5'b10000, 1'b0, 1'b0, "erase rom over cpu");
		add_step(K_RD, 25'h0000011, 1'b0, 5'b10000, 1'b0, 1'b0, "rd ram 0x0011 kept");
		add_step(K_RD, 25'h0000011, 1'b1, 5'b10000, 1'b0, 1'b0, "rd rom 0x0011 erased");
		// Reset and wait levels
		add_step(K_CTRL, 25'h0, 1'b1, 5'b10000, 1'b0, 1'b0, "ctrl running");
		add_step(K_CTRL, 25'h0, 1'b1, 5'b00000, 1'b1, 1'b1, "ctrl rom not loaded");
		add_step(K_CTRL, 25'h0, 1'b1, 5'b11000, 1'b1, 1'b0, "ctrl reset key");
		add_step(K_CTRL, 25'h0, 1'b1, 5'b10100, 1'b1, 1'b0, "ctrl erase busy");
		add_step(K_CTRL, 25'h0, 1'b1, 5'b10010, 1'b1, 1'b0, "ctrl menu reset");
		add_step(K_CTRL, 25'h0, 1'b1, 5'b10001, 1'b0, 1'b1, "ctrl download active");
		add_step(K_CTRL, 25'h0, 1'b1, 5'b00001, 1'b1, 1'b1, "ctrl boot download");
	endfunction

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------
	task automatic drive_idle();
		dl_active <= 1'b0;
		dl_wr <= 1'b0;
		erase_busy <= 1'b0;
		erase_wr <= 1'b0;
		cpu_wr <= 1'b0;
		cpu_rd <= 1'b0;
		rom_loaded <= 1'b1;
		reset_key <= 1'b0;
		menu_reset <= 1'b0;
	endtask

	task automatic apply_step(input int i);
		logic [lm80c_map_pkg::LOAD_ADDR_W-1:0] addr;
		lm80c_map_pkg::cpu_addr_t cpu_a;
		lm80c_map_pkg::data_t dl_byte;
		lm80c_map_pkg::data_t er_byte;
		lm80c_map_pkg::data_t cpu_byte;
		addr = step_addr[i];
		cpu_a = addr[lm80c_map_pkg::CPU_ADDR_W-1:0];
		dl_byte = lm80c_map_pkg::data_t'($random(seed));
		er_byte = lm80c_map_pkg::data_t'($random(seed));
		cpu_byte = lm80c_map_pkg::data_t'($random(seed));
		@(posedge clk_cpu);
		drive_idle();
		rom_enabled <= step_rom_en[i];
		// Download, erase and CPU sources all aim at the same byte
		if ((step_kind[i] == K_DL) || (step_kind[i] == K_ALL_WR)) begin
			dl_active <= 1'b1;
			dl_wr <= 1'b1;
			dl_addr <= addr;
			dl_data <= dl_byte;
		end
		if ((step_kind[i] == K_ER) || (step_kind[i] == K_ALL_WR) ||
				(step_kind[i] == K_ER_CPU_WR)) begin
			erase_busy <= 1'b1;
			erase_wr <= 1'b1;
			erase_addr <= addr;
			erase_data <= er_byte;
		end
		if ((step_kind[i] == K_CPU_WR) || (step_kind[i] == K_ALL_WR) ||
				(step_kind[i] == K_ER_CPU_WR)) begin
			cpu_wr <= 1'b1;
			cpu_addr <= cpu_a;
			cpu_wdata <= cpu_byte;
		end
		case (step_kind[i])
			K_DL, K_ALL_WR: store_loader(addr, dl_byte);
			K_ER, K_ER_CPU_WR: store_loader(addr, er_byte);
			K_CPU_WR: store_cpu(cpu_a, step_rom_en[i], cpu_byte);
			K_RD: begin
				cpu_rd <= 1'b1;
				cpu_addr <= cpu_a;
				exp_q.push_back(expect_read(cpu_a, step_rom_en[i]));
				exp_name_q.push_back(step_name[i]);
			end
			default: begin
				rom_loaded <= step_ctrl[i][4];
				reset_key <= step_ctrl[i][3];
				erase_busy <= step_ctrl[i][2];
				menu_reset <= step_ctrl[i][1];
				dl_active <= step_ctrl[i][0];
				// Levels are combinational, settled by the falling edge
				@(negedge clk_cpu);
				check_level({step_name[i], " cpu_reset"}, step_exp_reset[i], cpu_reset);
				check_level({step_name[i], " cpu_wait"}, step_exp_wait[i], cpu_wait);
			end
		endcase
	endtask

	// ------------------------------------------------------------------------
	// Read return monitor and timeout
	// ------------------------------------------------------------------------

	// Valid must follow cpu_rd by exactly two cycles
	always @(negedge clk_cpu) begin
		if (!rst) begin
			check_level("read valid timing", rd_d2, cpu_rdata_valid);
			if (cpu_rdata_valid) begin
				held_rdata = exp_q.pop_front();
				held_known = 1'b1;
				check_data(exp_name_q.pop_front(), held_rdata, cpu_rdata);
			end else if (held_known) begin
				check_data("read data hold", held_rdata, cpu_rdata);
			end
		end
		rd_d2 = rd_d1;
		rd_d1 = cpu_rd;
	end

	always @(posedge clk_cpu) begin
		cycle_cnt++;
		if ((timeout_limit != 0) && (cycle_cnt > timeout_limit)) begin
			$display("Timeout, test did not finish within %0d cycles", timeout_limit);
			abort_run();
		end
	end

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		rst = 1'b1;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		erase_busy = 1'b0;
		erase_wr = 1'b0;
		erase_addr = '0;
		erase_data = '0;
		rom_loaded = 1'b1;
		reset_key = 1'b0;
		menu_reset = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_wr = 1'b0;
		cpu_rd = 1'b0;
		rom_enabled = 1'b1;
		load_table();
		timeout_limit = 10 + 3 * step_kind.size() + 64;

		// Ten reset cycles, enables held low throughout
		repeat (9) begin
			@(negedge clk_cpu);
			check_level("cpu_ena in reset", 1'b0, cpu_ena);
			check_level("psg_ena in reset", 1'b0, psg_ena);
			check_level("vdp_ena in reset", 1'b0, vdp_ena);
			// Only rst holds the CPU here, every other reset source is idle
			check_level("cpu_reset in reset", 1'b1, cpu_reset);
		end
		@(posedge clk_cpu);
		rst <= 1'b0;

		for (int i = 0; i < step_kind.size(); i++) begin
			apply_step(i);
		end
		@(posedge clk_cpu);
		drive_idle();
		while (exp_q.size() != 0) begin
			@(negedge clk_cpu);
		end

		// One full divider period
		cpu_ena_cnt = '0;
		psg_ena_cnt = '0;
		vdp_ena_cnt = '0;
		repeat (16) begin
			@(negedge clk_cpu);
			if (cpu_ena) cpu_ena_cnt++;
			if (psg_ena) psg_ena_cnt++;
			if (vdp_ena) vdp_ena_cnt++;
		end
		check_count("cpu_ena per 16 cycles", 5'd2, cpu_ena_cnt);
		check_count("psg_ena per 16 cycles", 5'd1, psg_ena_cnt);
		check_count("vdp_ena per 16 cycles", 5'd4, vdp_ena_cnt);

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== bench/lm80c_mem_properties.sv ====
`timescale 1ns/1ps

module lm80c_mem_properties (
	input logic clk_cpu,
	input logic rst,
	input logic dl_active,
	input logic dl_wr,
	input logic [lm80c_map_pkg::LOAD_ADDR_W-1:0] dl_addr,
	input logic erase_busy,
	input logic erase_wr,
	input logic cpu_wr,
	input logic cpu_rom_sel,
	input logic rom_we,
	input logic ram_we
);

	logic dl_write;
	logic dl_ignored;
	logic loader_write;

	// Download strobe as the decoder qualifies it
	assign dl_write = dl_active && dl_wr;

	// Holes in the loader map, 0x08000 to 0x0FFFF and 0x20000 up
	assign dl_ignored = ((dl_addr >= 25'h0008000) && (dl_addr < 25'h0010000)) ||
		(dl_addr >= 25'h0020000);

	// Any loader-side write shadows the CPU
	assign loader_write = dl_write || (erase_busy && erase_wr);

	// ------------------------------------------------------------------------
	// Write decode properties
	// ------------------------------------------------------------------------

	// Only one array per cycle
	one_array_written: assert property (@(posedge clk_cpu) disable iff (rst)
		!(rom_we && ram_we))
		else $error("ROM and RAM write enables high in the same cycle");

	// Download into a hole writes nothing
	hole_not_written: assert property (@(posedge clk_cpu) disable iff (rst)
		(dl_write && dl_ignored) |-> (!rom_we && !ram_we))
		else $error("Download write to an unmapped address reached an array");

	// ROM overlay blocks CPU writes
	overlay_blocks_cpu: assert property (@(posedge clk_cpu) disable iff (rst)
		(cpu_wr && cpu_rom_sel && !loader_write) |-> !ram_we)
		else $error("CPU write under the ROM overlay reached RAM");

endmodule

// ==== bench/lm80c_clock_gen.sv ====
`timescale 1ns/1ps

module lm80c_clock_gen #(
	parameter int PERIOD_NS = 20
) (
	output logic clk_cpu
);

	// Starts low, first rising edge half a period in
	initial begin
		clk_cpu = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_cpu = ~clk_cpu;
		end
	end

endmodule

// ==== src/lm80c_mem_top.sv ====
`timescale 1ns/1ps

module lm80c_mem_top (
	input logic clk_cpu,
	input logic rst,
	// Download writes
	input logic dl_active,
	input logic dl_wr,
	input lm80c_map_pkg::load_addr_u dl_addr,
	input lm80c_map_pkg::data_t dl_data,
	// Erase writes
	input logic erase_busy,
	input logic erase_wr,
	input lm80c_map_pkg::load_addr_u erase_addr,
	input lm80c_map_pkg::data_t erase_data,
	// Boot and reset sources
	input logic rom_loaded,
	input logic reset_key,
	input logic menu_reset,
	// CPU bus
	input lm80c_map_pkg::cpu_addr_t cpu_addr,
	input lm80c_map_pkg::data_t cpu_wdata,
	input logic cpu_wr,
	input logic cpu_rd,
	input logic rom_enabled,
	output lm80c_map_pkg::data_t cpu_rdata,
	output logic cpu_rdata_valid,
	// CPU control levels
	output logic cpu_reset,
	output logic cpu_wait,
	// Clock enables
	output logic cpu_ena,
	output logic psg_ena,
	output logic vdp_ena
);

	// ROM write port
	logic rom_we;
	lm80c_map_pkg::rom_addr_t rom_waddr;
	lm80c_map_pkg::data_t rom_wdata;

	// RAM write port
	logic ram_we;
	lm80c_map_pkg::ram_addr_t ram_waddr;
	lm80c_map_pkg::data_t ram_wdata;

	// Array read data and CPU region select
	lm80c_map_pkg::data_t rom_rdata;
	lm80c_map_pkg::data_t ram_rdata;
	logic cpu_rom_sel;

	// ------------------------------------------------------------------------
	// Clock enables
	// ------------------------------------------------------------------------
	lm80c_clock_enables clock_enables_i (
		.clk_cpu(clk_cpu),
		.rst(rst),
		.cpu_ena(cpu_ena),
		.psg_ena(psg_ena),
		.vdp_ena(vdp_ena)
	);

	// ------------------------------------------------------------------------
	// Write decode and control levels
	// ------------------------------------------------------------------------
	lm80c_write_decode write_decode_i (
		.rst(rst),
		.dl_active(dl_active),
		.dl_wr(dl_wr),
		.dl_addr(dl_addr),
		.dl_data(dl_data),
		.erase_busy(erase_busy),
		.erase_wr(erase_wr),
		.erase_addr(erase_addr),
		.erase_data(erase_data),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_wr(cpu_wr),
		.rom_enabled(rom_enabled),
		.rom_loaded(rom_loaded),
		.reset_key(reset_key),
		.menu_reset(menu_reset),
		.rom_we(rom_we),
		.rom_waddr(rom_waddr),
		.rom_wdata(rom_wdata),
		.ram_we(ram_we),
		.ram_waddr(ram_waddr),
		.ram_wdata(ram_wdata),
		.cpu_rom_sel(cpu_rom_sel),
		.cpu_reset(cpu_reset),
		.cpu_wait(cpu_wait)
	);

	// ------------------------------------------------------------------------
	// Memory arrays
	// ------------------------------------------------------------------------

	// 32 KB ROM, CPU reads with the low 15 address bits
	lm80c_bram #(
		.ADDR_W(lm80c_map_pkg::ROM_ADDR_W)
	) rom_mem (
		.clk_cpu(clk_cpu),
		.we(rom_we),
		.waddr(rom_waddr),
		.wdata(rom_wdata),
		.raddr(cpu_addr[lm80c_map_pkg::ROM_ADDR_W-1:0]),
		.rdata(rom_rdata)
	);

	// 64 KB RAM
	lm80c_bram #(
		.ADDR_W(lm80c_map_pkg::RAM_ADDR_W)
	) ram_mem (
		.clk_cpu(clk_cpu),
		.we(ram_we),
		.waddr(ram_waddr),
		.wdata(ram_wdata),
		.raddr(cpu_addr),
		.rdata(ram_rdata)
	);

	// ------------------------------------------------------------------------
	// Read return
	// ------------------------------------------------------------------------
	lm80c_read_return read_return_i (
		.clk_cpu(clk_cpu),
		.rst(rst),
		.cpu_rd(cpu_rd),
		.cpu_rom_sel(cpu_rom_sel),
		.rom_rdata(rom_rdata),
		.ram_rdata(ram_rdata),
		.cpu_rdata(cpu_rdata),
		.cpu_rdata_valid(cpu_rdata_valid)
	);

endmodule

// ==== src/lm80c_read_return.sv ====
`timescale 1ns/1ps

module lm80c_read_return (
	input logic clk_cpu,
	input logic rst,
	input logic cpu_rd,
	input logic cpu_rom_sel,
	input lm80c_map_pkg::data_t rom_rdata,
	input lm80c_map_pkg::data_t ram_rdata,
	output lm80c_map_pkg::data_t cpu_rdata,
	output logic cpu_rdata_valid
);

	// Stage 1 state, lined up with the array read latency
	logic rd_q;
	logic rom_sel_q;

	// ------------------------------------------------------------------------
	// Stage 1
	// ------------------------------------------------------------------------

	// Strobe is control state and clears on reset
	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			rd_q <= 1'b0;
		end else begin
			rd_q <= cpu_rd;
		end
	end

	// Region select rides along with the strobe
	always_ff @(posedge clk_cpu) begin
		rom_sel_q <= cpu_rom_sel;
	end

	// ------------------------------------------------------------------------
	// Stage 2
	// ------------------------------------------------------------------------

	// Array data is valid now, pick the region and hold it
	always_ff @(posedge clk_cpu) begin
		if (rd_q) begin
			cpu_rdata <= rom_sel_q ? rom_rdata : ram_rdata;
		end
	end

	// One-cycle valid pulse, two cycles after cpu_rd
	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			cpu_rdata_valid <= 1'b0;
		end else begin
			cpu_rdata_valid <= rd_q;
		end
	end

endmodule

// ==== src/lm80c_bram.sv ====
`timescale 1ns/1ps

module lm80c_bram #(
	parameter int ADDR_W = 15
) (
	input logic clk_cpu,
	// Write port
	input logic we,
	input logic [ADDR_W-1:0] waddr,
	input lm80c_map_pkg::data_t wdata,
	// Read port
	input logic [ADDR_W-1:0] raddr,
	output lm80c_map_pkg::data_t rdata
);

	// Byte array, 2**ADDR_W deep
	lm80c_map_pkg::data_t mem [0:(1 << ADDR_W)-1];

	// Write commits on the sampling edge
	always_ff @(posedge clk_cpu) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, one cycle after the address
	// Same-address write in that cycle returns the old byte
	always_ff @(posedge clk_cpu) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== src/lm80c_write_decode.sv ====
`timescale 1ns/1ps

module lm80c_write_decode (
	input logic rst,
	// Download source
	input logic dl_active,
	input logic dl_wr,
	input lm80c_map_pkg::load_addr_u dl_addr,
	input lm80c_map_pkg::data_t dl_data,
	// Erase source
	input logic erase_busy,
	input logic erase_wr,
	input lm80c_map_pkg::load_addr_u erase_addr,
	input lm80c_map_pkg::data_t erase_data,
	// CPU source
	input lm80c_map_pkg::cpu_addr_t cpu_addr,
	input lm80c_map_pkg::data_t cpu_wdata,
	input logic cpu_wr,
	// Map and control inputs
	input logic rom_enabled,
	input logic rom_loaded,
	input logic reset_key,
	input logic menu_reset,
	// ROM write port
	output logic rom_we,
	output lm80c_map_pkg::rom_addr_t rom_waddr,
	output lm80c_map_pkg::data_t rom_wdata,
	// RAM write port
	output logic ram_we,
	output lm80c_map_pkg::ram_addr_t ram_waddr,
	output lm80c_map_pkg::data_t ram_wdata,
	// CPU side levels
	output logic cpu_rom_sel,
	output logic cpu_reset,
	output logic cpu_wait
);

	// Winning loader-side write, download or erase
	logic ld_wr;
	lm80c_map_pkg::load_addr_u ld_addr;
	lm80c_map_pkg::data_t ld_data;

	// Per-target write qualifiers
	logic ld_to_rom;
	logic ld_to_ram;
	logic cpu_to_ram;

	// ------------------------------------------------------------------------
	// Source arbitration
	// ------------------------------------------------------------------------

	// Download beats erase, erase beats the CPU
	always_comb begin
		ld_wr = 1'b0;
		ld_addr = erase_addr;
		ld_data = erase_data;
		if (dl_active && dl_wr) begin
			ld_wr = 1'b1;
			ld_addr = dl_addr;
			ld_data = dl_data;
		end else if (erase_busy && erase_wr) begin
			ld_wr = 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// Region decode
	// ------------------------------------------------------------------------

	// ROM view: region zero is the 32 KB ROM image
	assign ld_to_rom = ld_wr && (ld_addr.rom.region == lm80c_map_pkg::ROM_REGION);

	// RAM view: bank one is the 64 KB RAM image
	// Anything else (0x08000-0x0FFFF, 0x20000 up) falls through unwritten
	assign ld_to_ram = ld_wr && (ld_addr.ram.bank == lm80c_map_pkg::RAM_BANK);

	// ROM overlay on the low 32 KB of the CPU space
	assign cpu_rom_sel = rom_enabled && (cpu_addr < lm80c_map_pkg::CPU_ROM_TOP);

	// CPU only writes when no loader write is pending, never into the overlay
	assign cpu_to_ram = !ld_wr && cpu_wr && !cpu_rom_sel;

	// ------------------------------------------------------------------------
	// Write ports
	// ------------------------------------------------------------------------

	// ROM is only reachable from the loader side
	assign rom_we = ld_to_rom;
	assign rom_waddr = ld_addr.rom.offset;
	assign rom_wdata = ld_data;

	// RAM takes loader or CPU data
	assign ram_we = ld_to_ram || cpu_to_ram;
	assign ram_waddr = ld_wr ? ld_addr.ram.offset : cpu_addr;
	assign ram_wdata = ld_wr ? ld_data : cpu_wdata;

	// ------------------------------------------------------------------------
	// CPU control levels
	// ------------------------------------------------------------------------

	// Hold the CPU in reset while booting, erasing or on a key or menu reset
	assign cpu_reset = rst || reset_key || erase_busy || menu_reset || !rom_loaded;

	// Stall the CPU until the ROM is in and while a download runs
	assign cpu_wait = !rom_loaded || dl_active;

endmodule

// ==== src/lm80c_clock_enables.sv ====
`timescale 1ns/1ps

module lm80c_clock_enables (
	input logic clk_cpu,
	input logic rst,
	output logic cpu_ena,
	output logic psg_ena,
	output logic vdp_ena
);

	// Free-running phase counter
	logic [lm80c_timing_pkg::ENA_DIV_W-1:0] div_cnt;

	// Phase hits, decoded from the current counter value
	logic cpu_hit;
	logic psg_hit;
	logic vdp_hit;

	// ------------------------------------------------------------------------
	// Phase decode
	// ------------------------------------------------------------------------

	// CPU at phases 0 and 8
	assign cpu_hit = (div_cnt == lm80c_timing_pkg::CPU_ENA_PHASE_A) ||
		(div_cnt == lm80c_timing_pkg::CPU_ENA_PHASE_B);

	// Sound once per period
	assign psg_hit = (div_cnt == lm80c_timing_pkg::PSG_ENA_PHASE);

	// Video every fourth cycle
	assign vdp_hit = (div_cnt[lm80c_timing_pkg::VDP_DIV_W-1:0] == '0);

	// ------------------------------------------------------------------------
	// Counter and registered enables
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			// Counter restarts at 0, all enables held low
			div_cnt <= '0;
			cpu_ena <= 1'b0;
			psg_ena <= 1'b0;
			vdp_ena <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			// Enables lag the counter by one cycle
			cpu_ena <= cpu_hit;
			psg_ena <= psg_hit;
			vdp_ena <= vdp_hit;
		end
	end

endmodule

// ==== src/lm80c_timing_pkg.sv ====
package lm80c_timing_pkg;

	// ------------------------------------------------------------------------
	// Clock enable divider
	// ------------------------------------------------------------------------

	// One divider period is 16 clk_cpu cycles
	parameter int ENA_DIV_W = 4;

	// CPU runs at an eighth of clk_cpu, two pulses per period
	parameter logic [ENA_DIV_W-1:0] CPU_ENA_PHASE_A = 4'd0;
	parameter logic [ENA_DIV_W-1:0] CPU_ENA_PHASE_B = 4'd8;

	// Sound chip gets one pulse per period
	parameter logic [ENA_DIV_W-1:0] PSG_ENA_PHASE = 4'd0;

	// Video enable fires whenever these low bits are all zero
	parameter int VDP_DIV_W = 2;

endpackage

// ==== src/lm80c_map_pkg.sv ====
package lm80c_map_pkg;

	// ------------------------------------------------------------------------
	// Data and address widths
	// ------------------------------------------------------------------------

	// Every data path is one byte wide
	parameter int DATA_W = 8;

	// CPU sees a flat 64 KB space
	parameter int CPU_ADDR_W = 16;

	// 32 KB ROM array and 64 KB RAM array
	parameter int ROM_ADDR_W = 15;
	parameter int RAM_ADDR_W = 16;

	// Loader and eraser use the wide download address
	parameter int LOAD_ADDR_W = 25;

	// Upper fields left over by each view of the loader address
	parameter int ROM_REGION_W = LOAD_ADDR_W - ROM_ADDR_W;
	parameter int RAM_BANK_W = LOAD_ADDR_W - RAM_ADDR_W;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
	typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

	// ------------------------------------------------------------------------
	// Region constants
	// ------------------------------------------------------------------------

	// Loader region zero covers 0x00000 to 0x07FFF, the ROM image
	parameter logic [ROM_REGION_W-1:0] ROM_REGION = '0;

	// Bank one covers 0x10000 to 0x1FFFF, the RAM image
	parameter logic [RAM_BANK_W-1:0] RAM_BANK = RAM_BANK_W'(1);

	// ROM overlays the CPU space below this address when enabled
	parameter cpu_addr_t CPU_ROM_TOP = 16'h8000;

	// ------------------------------------------------------------------------
	// Loader address, decoded as ROM offset or as RAM offset
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [ROM_REGION_W-1:0] region;
		rom_addr_t offset;
	} load_rom_view_t;

	typedef struct packed {
		logic [RAM_BANK_W-1:0] bank;
		ram_addr_t offset;
	} load_ram_view_t;

	typedef union packed {
		load_rom_view_t rom;
		load_ram_view_t ram;
	} load_addr_u;

endpackage
